// ==== src/chess_settings.svh ====
`ifndef CHESS_SETTINGS_SVH
`define CHESS_SETTINGS_SVH

// Bits per square and squares per board.
`define CHESS_PIECE_WIDTH 4
`define CHESS_SQUARES 64

// Packed board, square n at bits n*4 up to n*4+3.
`define CHESS_BOARD_WIDTH (`CHESS_PIECE_WIDTH * `CHESS_SQUARES)

`define CHESS_CHAR_WIDTH 8

`endif

// ==== src/chess_pkg.sv ====
`default_nettype none

`include "chess_settings.svh"

package chess_pkg;

   // Bit 3 is the colour, so each black code is its white code plus 8.
   typedef enum logic [`CHESS_PIECE_WIDTH-1:0] {
      empty_square = 4'd0,
      white_pawn   = 4'd1,
      white_rook   = 4'd2,
      white_knight = 4'd3,
      white_bishop = 4'd4,
      white_king   = 4'd5,
      white_queen  = 4'd6,
      black_pawn   = 4'd9,
      black_rook   = 4'd10,
      black_knight = 4'd11,
      black_bishop = 4'd12,
      black_king   = 4'd13,
      black_queen  = 4'd14
   } piece_t;

   // Rank times 8 plus file, a1 is square 0.
   typedef logic [$clog2(`CHESS_SQUARES)-1:0] square_t;

   typedef enum logic [1:0] {
      tok_piece,
      tok_space,
      tok_newline
   } token_kind_t;

endpackage

`default_nettype wire

// ==== src/board_store.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "chess_settings.svh"

module board_store (
   input  wire                           clk,
   input  wire                           reset,
   input  wire                           new_game,
   input  wire                           move_valid,
   input  chess_pkg::square_t            from_square,
   input  chess_pkg::square_t            to_square,
   output logic [`CHESS_BOARD_WIDTH-1:0] board,
   output logic [3:0]                    castle_mask,
   output logic [3:0]                    en_passant_col,
   output logic                          capture
);
   import chess_pkg::*;

   localparam int pw = `CHESS_PIECE_WIDTH;

   logic [`CHESS_BOARD_WIDTH-1:0] board_next;
   piece_t     moved;
   piece_t     target;
   logic [2:0] from_rank, from_file, to_rank, to_file;
   logic       is_king, is_pawn;
   logic       castle_king, castle_queen;
   logic       ep_take, double_push;
   logic [3:0] castle_clear;

   function automatic logic [`CHESS_BOARD_WIDTH-1:0] start_board();
      logic [`CHESS_BOARD_WIDTH-1:0] b;
      piece_t back;
      b = '0;
      for (int f = 0; f < 8; f++)
      begin
         case (f)
            0, 7:    back = white_rook;
            1, 6:    back = white_knight;
            2, 5:    back = white_bishop;
            3:       back = white_queen;
            default: back = white_king;
         endcase
         b[pw*f +: pw]        = back;
         b[pw*(8+f) +: pw]    = white_pawn;
         b[pw*(48+f) +: pw]   = black_pawn;
         b[pw*(56+f) +: pw]   = back | 4'b1000; // Black back rank.
      end
      return b;
   endfunction

   // Castle bits lost when a king or rook home square is touched.
   function automatic logic [3:0] home_mask(input square_t sq);
      case (sq)
         6'd4:    return 4'b0011;
         6'd7:    return 4'b0001;
         6'd0:    return 4'b0010;
         6'd60:   return 4'b1100;
         6'd63:   return 4'b0100;
         6'd56:   return 4'b1000;
         default: return 4'b0000;
      endcase
   endfunction

   assign from_rank = from_square[5:3];
   assign from_file = from_square[2:0];
   assign to_rank   = to_square[5:3];
   assign to_file   = to_square[2:0];

   assign moved  = piece_t'(board[pw*from_square +: pw]);
   assign target = piece_t'(board[pw*to_square +: pw]);

   assign is_king = (moved == white_king) || (moved == black_king);
   assign is_pawn = (moved == white_pawn) || (moved == black_pawn);

   assign castle_king  = is_king && (to_file == from_file + 3'd2);
   assign castle_queen = is_king && (from_file == to_file + 3'd2);

   // Diagonal pawn step onto an empty square in the en-passant file.
   assign ep_take = is_pawn && (from_file != to_file) && (target == empty_square)
                    && en_passant_col[3] && (to_file == en_passant_col[2:0]);

   assign double_push = is_pawn && ((to_rank == from_rank + 3'd2) ||
                                    (from_rank == to_rank + 3'd2));

   assign castle_clear = home_mask(from_square) | home_mask(to_square);

   always_comb
   begin
      board_next = board;
      board_next[pw*to_square +: pw]   = moved;
      board_next[pw*from_square +: pw] = empty_square;
      if (castle_king)
      begin
         board_next[pw*{from_rank, 3'd5} +: pw] = board[pw*{from_rank, 3'd7} +: pw];
         board_next[pw*{from_rank, 3'd7} +: pw] = empty_square;
      end
      if (castle_queen)
      begin
         board_next[pw*{from_rank, 3'd3} +: pw] = board[pw*{from_rank, 3'd0} +: pw];
         board_next[pw*{from_rank, 3'd0} +: pw] = empty_square;
      end
      if (ep_take)
         board_next[pw*{from_rank, to_file} +: pw] = empty_square; // Taken pawn.
   end

   always_ff @(posedge clk)
   begin
      if (reset || new_game)
      begin
         board          <= start_board();
         castle_mask    <= 4'b1111;
         en_passant_col <= 4'b0000;
         capture        <= 1'b0;
      end
      else if (move_valid)
      begin
         board          <= board_next;
         castle_mask    <= castle_mask & ~castle_clear;
         en_passant_col <= double_push ? {1'b1, from_file} : 4'b0000;
         capture        <= (target != empty_square) || ep_take;
      end
   end

   a_move_distinct : assert property (@(posedge clk) disable iff (reset)
      move_valid |-> from_square != to_square);

endmodule

`default_nettype wire

// ==== src/board_scanner.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "chess_settings.svh"

module board_scanner (
   input  wire                            clk,
   input  wire                            reset,
   input  wire                            display,
   input  wire [`CHESS_BOARD_WIDTH-1:0]   board,
   output logic                           token_valid,
   output chess_pkg::token_kind_t         token_kind,
   output chess_pkg::piece_t              token_piece,
   output logic                           board_last
);
   import chess_pkg::*;

   localparam int pw = `CHESS_PIECE_WIDTH;

   typedef enum logic {s_idle, s_scan} state_t;

   state_t      state;
   logic [2:0]  rank;
   logic [3:0]  file;   // File 8 is the newline slot.
   logic        phase;  // Space after the piece.
   square_t     square;
   token_kind_t kind;

   assign square = {rank, file[2:0]};
   assign kind   = file[3] ? tok_newline : (phase ? tok_space : tok_piece);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state       <= s_idle;
         token_valid <= 1'b0;
         board_last  <= 1'b0;
         rank        <= 3'd7;
         file        <= 4'd0;
         phase       <= 1'b0;
      end
      else
      begin
         token_valid <= 1'b0;
         board_last  <= 1'b0;
         case (state)
            s_idle:
               if (display)
               begin
                  state <= s_scan;
                  rank  <= 3'd7;  // Rank 8 first.
                  file  <= 4'd0;
                  phase <= 1'b0;
               end
            s_scan:
            begin
               token_valid <= 1'b1;
               if (file[3])
               begin
                  file <= 4'd0;
                  rank <= rank - 3'd1;
                  if (rank == 3'd0)
                  begin
                     board_last <= 1'b1;
                     state      <= s_idle;
                  end
               end
               else if (phase)
               begin
                  phase <= 1'b0;
                  file  <= file + 4'd1;
               end
               else
                  phase <= 1'b1;
            end
            default: state <= s_idle;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      token_kind  <= kind;
      token_piece <= piece_t'(board[pw*square +: pw]);
   end

   // One unbroken run of 136 tokens per request, then nothing while idle.
   a_scan_length : assert property (@(posedge clk) disable iff (reset)
      state == s_idle && display |-> ##2 token_valid [*136] ##1 !token_valid);

endmodule

`default_nettype wire

// ==== src/glyph_encoder.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "chess_settings.svh"

module glyph_encoder (
   input  wire                           clk,
   input  wire                           reset,
   input  wire                           token_valid,
   input  chess_pkg::token_kind_t        token_kind,
   input  chess_pkg::piece_t             token_piece,
   input  wire                           board_last,
   output logic                          glyph_valid,
   output logic [`CHESS_CHAR_WIDTH-1:0]  glyph,
   output logic                          glyph_last
);
   import chess_pkg::*;

   function automatic logic [`CHESS_CHAR_WIDTH-1:0] piece_letter(input piece_t p);
      case (p)
         white_pawn:   return "P";
         white_rook:   return "R";
         white_knight: return "N";
         white_bishop: return "B";
         white_king:   return "K";
         white_queen:  return "Q";
         black_pawn:   return "p";
         black_rook:   return "r";
         black_knight: return "n";
         black_bishop: return "b";
         black_king:   return "k";
         black_queen:  return "q";
         default:      return ".";
      endcase
   endfunction

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         glyph_valid <= 1'b0;
         glyph_last  <= 1'b0;
      end
      else
      begin
         glyph_valid <= token_valid;
         glyph_last  <= token_valid && board_last;
      end
   end

   always_ff @(posedge clk)
   begin
      case (token_kind)
         tok_space:   glyph <= " ";
         tok_newline: glyph <= 8'h0a;
         default:     glyph <= piece_letter(token_piece);
      endcase
   end

endmodule

`default_nettype wire

// ==== src/status_appender.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "chess_settings.svh"

module status_appender (
   input  wire                           clk,
   input  wire                           reset,
   input  wire                           display,
   input  wire                           white_in_check,
   input  wire                           black_in_check,
   input  wire [3:0]                     castle_mask,
   input  wire [3:0]                     en_passant_col,
   input  wire                           capture,
   input  wire                           glyph_valid,
   input  wire [`CHESS_CHAR_WIDTH-1:0]   glyph,
   input  wire                           glyph_last,
   output logic                          char_valid,
   output logic [`CHESS_CHAR_WIDTH-1:0]  char_data,
   output logic                          display_done
);
   // A 16 character check slot followed by the 38 character status line.
   localparam int tail_len = 54;

   typedef enum logic [1:0] {s_idle, s_board, s_status, s_done} state_t;

   state_t     state;
   logic [1:0] check_sel;  // {white, black}.
   logic [3:0] castle_q;
   logic [3:0] ep_q;
   logic       capture_q;
   logic [5:0] idx;
   logic [5:0] start_idx;

   logic [8*16-1:0]       check_text;
   logic [8*38-1:0]       status_line;
   logic [8*tail_len-1:0] tail;
   logic [`CHESS_CHAR_WIDTH-1:0] tail_char;

   function automatic logic [7:0] digit(input logic b);
      return b ? "1" : "0";
   endfunction

   always_comb
   begin
      case (check_sel)
         2'b11:
         begin
            check_text = {8'h00, "Both in check!\n"};
            start_idx  = 6'd1;
         end
         2'b10:
         begin
            check_text = "White in check.\n";
            start_idx  = 6'd0;
         end
         2'b01:
         begin
            check_text = "Black in check.\n";
            start_idx  = 6'd0;
         end
         default:
         begin
            check_text = '0;
            start_idx  = 6'd16; // Skip the check slot.
         end
      endcase
   end

   assign status_line = {"castle=",
                         digit(castle_q[3]), digit(castle_q[2]),
                         digit(castle_q[1]), digit(castle_q[0]),
                         " en_passant=",
                         digit(ep_q[3]), digit(ep_q[2]),
                         digit(ep_q[1]), digit(ep_q[0]),
                         " capture=", digit(capture_q), "\n"};

   assign tail      = {check_text, status_line};
   assign tail_char = tail[8*(tail_len-1-idx) +: 8];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state        <= s_idle;
         char_valid   <= 1'b0;
         display_done <= 1'b0;
         idx          <= 6'd0;
      end
      else
      begin
         display_done <= 1'b0;
         char_valid   <= glyph_valid;
         case (state)
            s_idle:
               if (display)
               begin
                  check_sel <= {white_in_check, black_in_check};
                  state     <= s_board;
               end
            s_board:
               if (glyph_valid && glyph_last)
               begin
                  castle_q  <= castle_mask;
                  ep_q      <= en_passant_col;
                  capture_q <= capture;
                  idx       <= start_idx;
                  state     <= s_status;
               end
            s_status:
            begin
               char_valid <= 1'b1;
               idx        <= idx + 6'd1;
               if (idx == 6'(tail_len - 1))
                  state <= s_done;
            end
            s_done:
            begin
               display_done <= 1'b1;
               state        <= s_idle;
            end
            default: state <= s_idle;
         endcase
      end
   end

   always_ff @(posedge clk)
      char_data <= (state == s_status) ? tail_char : glyph;

   a_no_glyph_in_status : assert property (@(posedge clk) disable iff (reset)
      state == s_status |-> !glyph_valid);

endmodule

`default_nettype wire

// ==== src/board_display_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "chess_settings.svh"

module board_display_top (
   input  wire                           clk,
   input  wire                           reset,
   input  wire                           new_game,
   input  wire                           move_valid,
   input  chess_pkg::square_t            from_square,
   input  chess_pkg::square_t            to_square,
   input  wire                           display,
   input  wire                           white_in_check,
   input  wire                           black_in_check,
   output logic                          char_valid,
   output logic [`CHESS_CHAR_WIDTH-1:0]  char_data,
   output logic                          display_done
);
   import chess_pkg::*;

   logic [`CHESS_BOARD_WIDTH-1:0] board;
   logic [3:0]                    castle_mask;
   logic [3:0]                    en_passant_col;
   logic                          capture;
   logic                          token_valid;
   token_kind_t                   token_kind;
   piece_t                        token_piece;
   logic                          board_last;
   logic                          glyph_valid;
   logic [`CHESS_CHAR_WIDTH-1:0]  glyph;
   logic                          glyph_last;

   board_store u_store (
      .clk            (clk),
      .reset          (reset),
      .new_game       (new_game),
      .move_valid     (move_valid),
      .from_square    (from_square),
      .to_square      (to_square),
      .board          (board),
      .castle_mask    (castle_mask),
      .en_passant_col (en_passant_col),
      .capture        (capture)
   );

   board_scanner u_scanner (
      .clk         (clk),
      .reset       (reset),
      .display     (display),
      .board       (board),
      .token_valid (token_valid),
      .token_kind  (token_kind),
      .token_piece (token_piece),
      .board_last  (board_last)
   );

   glyph_encoder u_encoder (
      .clk         (clk),
      .reset       (reset),
      .token_valid (token_valid),
      .token_kind  (token_kind),
      .token_piece (token_piece),
      .board_last  (board_last),
      .glyph_valid (glyph_valid),
      .glyph       (glyph),
      .glyph_last  (glyph_last)
   );

   status_appender u_appender (
      .clk            (clk),
      .reset          (reset),
      .display        (display),
      .white_in_check (white_in_check),
      .black_in_check (black_in_check),
      .castle_mask    (castle_mask),
      .en_passant_col (en_passant_col),
      .capture        (capture),
      .glyph_valid    (glyph_valid),
      .glyph          (glyph),
      .glyph_last     (glyph_last),
      .char_valid     (char_valid),
      .char_data      (char_data),
      .display_done   (display_done)
   );

endmodule

`default_nettype wire

// ==== verification/tb_board_display.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_board_display;

   localparam int done_timeout = 400;

   logic       clk;
   logic       reset;
   logic       new_game;
   logic       move_valid;
   logic [5:0] from_square;
   logic [5:0] to_square;
   logic       display;
   logic       white_in_check;
   logic       black_in_check;
   wire        char_valid;
   wire  [7:0] char_data;
   wire        display_done;

   // Reference position, kept in step with every move sent to the DUT.
   logic [3:0] ref_board [64];
   logic [3:0] ref_castle;
   logic [3:0] ref_ep;
   logic       ref_capture;

   logic [7:0] expected [$];
   logic [7:0] received [$];

   integer seed;
   int     checks;
   int     errors;
   int     timeouts;
   int     tests_run;
   int     tests_failed;

   board_display_top u_dut (
      .clk            (clk),
      .reset          (reset),
      .new_game       (new_game),
      .move_valid     (move_valid),
      .from_square    (from_square),
      .to_square      (to_square),
      .display        (display),
      .white_in_check (white_in_check),
      .black_in_check (black_in_check),
      .char_valid     (char_valid),
      .char_data      (char_data),
      .display_done   (display_done)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [31:0] exp_value,
                              input logic [31:0] act_value);
      checks++;
      if (exp_value !== act_value)
      begin
         errors++;
         $display("error at %0t: %s expected 0x%0h, got 0x%0h",
                  $time, name, exp_value, act_value);
      end
   endtask

   // Home rank from file a to file h, white codes.
   function automatic logic [3:0] back_rank_piece(input int f);
      case (f)
         0, 7:    return 4'd2;
         1, 6:    return 4'd3;
         2, 5:    return 4'd4;
         3:       return 4'd6;
         default: return 4'd5;
      endcase
   endfunction

   function automatic logic [3:0] rights_lost(input int sq);
      case (sq)
         4:       return 4'b0011; // e1.
         7:       return 4'b0001;
         0:       return 4'b0010;
         60:      return 4'b1100; // e8.
         63:      return 4'b0100;
         56:      return 4'b1000;
         default: return 4'b0000;
      endcase
   endfunction

   function automatic logic [7:0] piece_char(input logic [3:0] code);
      logic [7:0] c;
      case (code[2:0])
         3'd1:    c = "P";
         3'd2:    c = "R";
         3'd3:    c = "N";
         3'd4:    c = "B";
         3'd5:    c = "K";
         3'd6:    c = "Q";
         default: c = ".";
      endcase
      if (code[3] && c != ".")
         c = c + 8'd32;  // Black in lower case.
      return c;
   endfunction

   task automatic setup_start_board();
      for (int sq = 0; sq < 64; sq++)
         ref_board[sq] = 4'd0;
      for (int f = 0; f < 8; f++)
      begin
         ref_board[f]      = back_rank_piece(f);
         ref_board[8 + f]  = 4'd1;
         ref_board[48 + f] = 4'd9;
         ref_board[56 + f] = back_rank_piece(f) + 4'd8;
      end
      ref_castle  = 4'b1111;
      ref_ep      = 4'b0000;
      ref_capture = 1'b0;
   endtask

   task automatic update_board(input int src, input int dst);
      logic [3:0] piece;
      logic [3:0] target;
      int         fr;
      int         ff;
      int         tr;
      int         tf;
      logic       is_king;
      logic       is_pawn;
      logic       ep_take;
      piece   = ref_board[src];
      target  = ref_board[dst];
      fr      = src / 8;
      ff      = src % 8;
      tr      = dst / 8;
      tf      = dst % 8;
      is_king = (piece[2:0] == 3'd5);
      is_pawn = (piece[2:0] == 3'd1);
      ep_take = is_pawn && (ff != tf) && (target == 4'd0) && ref_ep[3]
                && (tf == ref_ep[2:0]);
      ref_board[dst] = piece;
      ref_board[src] = 4'd0;
      if (is_king && (tf - ff == 2))
      begin
         ref_board[fr*8 + 5] = ref_board[fr*8 + 7];
         ref_board[fr*8 + 7] = 4'd0;
      end
      if (is_king && (ff - tf == 2))
      begin
         ref_board[fr*8 + 3] = ref_board[fr*8];
         ref_board[fr*8]     = 4'd0;
      end
      if (ep_take)
         ref_board[fr*8 + tf] = 4'd0; // Pawn beside the taker.
      ref_capture = (target != 4'd0) || ep_take;
      ref_castle  = ref_castle & ~rights_lost(src) & ~rights_lost(dst);
      if (is_pawn && ((tr - fr == 2) || (fr - tr == 2)))
         ref_ep = {1'b1, ff[2:0]};
      else
         ref_ep = 4'b0000;
   endtask

   task automatic push_text(input string s);
      for (int i = 0; i < s.len(); i++)
         expected.push_back(s[i]);
   endtask

   task automatic push_bits(input logic [3:0] v);
      for (int i = 3; i >= 0; i--)
         expected.push_back(v[i] ? "1" : "0");
   endtask

   task automatic build_expected(input logic w, input logic b);
      expected.delete();
      for (int r = 7; r >= 0; r--)
      begin
         for (int f = 0; f < 8; f++)
         begin
            expected.push_back(piece_char(ref_board[r*8 + f]));
            expected.push_back(" ");
         end
         expected.push_back(8'h0a);
      end
      if (w && b)
         push_text("Both in check!\n");
      else if (w)
         push_text("White in check.\n");
      else if (b)
         push_text("Black in check.\n");
      push_text("castle=");
      push_bits(ref_castle);
      push_text(" en_passant=");
      push_bits(ref_ep);
      push_text(" capture=");
      expected.push_back(ref_capture ? "1" : "0");
      expected.push_back(8'h0a);
   endtask

   task automatic apply_move(input int src, input int dst);
      @(posedge clk);
      #2;
      move_valid  = 1'b1;
      from_square = src[5:0];
      to_square   = dst[5:0];
      @(posedge clk);
      #2;
      move_valid = 1'b0;
      update_board(src, dst);
   endtask

   task automatic load_new_game();
      @(posedge clk);
      #2;
      new_game = 1'b1;
      @(posedge clk);
      #2;
      new_game = 1'b0;
      setup_start_board();
   endtask

   // Cycles are counted in edges after the edge that samples the request.
   task automatic run_display(input logic w, input logic b, input bit second_strobe);
      int n;
      int first_n;
      int last_n;
      int done_n;
      int done_count;
      int stray;
      build_expected(w, b);
      received.delete();
      n          = 0;
      first_n    = -1;
      last_n     = -1;
      done_n     = -1;
      done_count = 0;
      stray      = 0;
      @(posedge clk);
      #2;
      display        = 1'b1;
      white_in_check = w;
      black_in_check = b;
      @(posedge clk);
      #2;
      display = 1'b0;
      while (done_count == 0 && n < done_timeout)
      begin
         @(posedge clk);
         #2;
         n++;
         display = second_strobe && (n == 10);  // Lands in the middle of the scan.
         if (char_valid)
         begin
            received.push_back(char_data);
            if (first_n < 0)
               first_n = n;
            last_n = n;
         end
         if (display_done)
         begin
            done_count++;
            done_n = n;
         end
      end
      if (done_count == 0)
      begin
         timeouts++;
         $display("timeout: no display_done within %0d cycles of the display request",
                  done_timeout);
      end
      else
      begin
         repeat (4)
         begin
            @(posedge clk);
            #2;
            if (char_valid)
               stray++;
            if (display_done)
               done_count++;
         end
         check_value("char count", expected.size(), received.size());
         for (int i = 0; i < expected.size() && i < received.size(); i++)
            check_value($sformatf("char_data[%0d]", i), expected[i], received[i]);
         check_value("first char_valid cycle", 3, first_n);
         check_value("char_valid run length", received.size(), last_n - first_n + 1);
         check_value("display_done cycle", last_n + 1, done_n);
         check_value("display_done pulses", 1, done_count);
         check_value("char_valid after done", 0, stray);
      end
   endtask

   task automatic report_test(input string name, input int errors_before,
                              input int timeouts_before);
      tests_run++;
      if (errors == errors_before && timeouts == timeouts_before)
         $display("test %s: ok", name);
      else
      begin
         tests_failed++;
         $display("test %s: failed", name);
      end
   endtask

   task automatic show_start_position();
      int e0;
      int t0;
      e0 = errors;
      t0 = timeouts;
      run_display(1'b0, 1'b0, 1'b0);
      if (received.size() > 136)
         check_value("char after rank 1", "c", received[136]);
      report_test("start_position", e0, t0);
   endtask

   task automatic play_quiet_moves();
      int e0;
      int t0;
      e0 = errors;
      t0 = timeouts;
      apply_move(12, 28);  // e2-e4.
      run_display(1'b0, 1'b0, 1'b0);
      apply_move(6, 21);   // g1-f3.
      run_display(1'b0, 1'b0, 1'b0);
      report_test("quiet_moves", e0, t0);
   endtask

   task automatic play_captures();
      int e0;
      int t0;
      e0 = errors;
      t0 = timeouts;
      apply_move(51, 35);
      apply_move(28, 35);  // e4 takes d5.
      run_display(1'b0, 1'b0, 1'b0);
      apply_move(50, 34);
      apply_move(35, 42);  // d5 takes c6 en passant.
      run_display(1'b0, 1'b0, 1'b0);
      report_test("captures", e0, t0);
   endtask

   task automatic play_castling();
      int e0;
      int t0;
      e0 = errors;
      t0 = timeouts;
      apply_move(5, 12);
      apply_move(4, 6);    // King side castle.
      run_display(1'b0, 1'b0, 1'b0);
      apply_move(48, 40);
      apply_move(56, 48);  // Rook leaves a8.
      run_display(1'b0, 1'b0, 1'b0);
      report_test("castling", e0, t0);
   endtask

   task automatic sweep_check_flags();
      int e0;
      int t0;
      int order [4];
      int j;
      int tmp;
      e0 = errors;
      t0 = timeouts;
      for (int i = 0; i < 4; i++)
         order[i] = i;
      for (int i = 3; i > 0; i--)
      begin
         j        = ($random(seed) & 32'h7fff_ffff) % (i + 1);
         tmp      = order[i];
         order[i] = order[j];
         order[j] = tmp;
      end
      for (int i = 0; i < 4; i++)
         run_display(order[i][1], order[i][0], 1'b0);
      white_in_check = 1'b0;
      black_in_check = 1'b0;
      report_test("check_flags", e0, t0);
   endtask

   task automatic restart_game();
      int e0;
      int t0;
      e0 = errors;
      t0 = timeouts;
      apply_move(11, 27);
      load_new_game();
      run_display(1'b0, 1'b0, 1'b1);
      report_test("new_game", e0, t0);
   endtask

   initial
   begin
      seed           = 23;
      checks         = 0;
      errors         = 0;
      timeouts       = 0;
      tests_run      = 0;
      tests_failed   = 0;
      reset          = 1'b1;
      new_game       = 1'b0;
      move_valid     = 1'b0;
      from_square    = 6'd0;
      to_square      = 6'd0;
      display        = 1'b0;
      white_in_check = 1'b0;
      black_in_check = 1'b0;
      setup_start_board();
      repeat (3) @(posedge clk);
      #2;
      reset = 1'b0;
      show_start_position();
      play_quiet_moves();
      play_captures();
      play_castling();
      sweep_check_flags();
      restart_game();
      $display("tests run %0d, failed %0d, checks %0d, errors %0d, timeouts %0d",
               tests_run, tests_failed, checks, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+src
src/chess_pkg.sv
src/board_store.sv
src/board_scanner.sv
src/glyph_encoder.sv
src/status_appender.sv
src/board_display_top.sv
verification/tb_board_display.sv

// ==== Bender.yml ====
package:
  name: chess_board_display

sources:
  - include_dirs:
      - src
    files:
      - src/chess_pkg.sv
      - src/board_store.sv
      - src/board_scanner.sv
      - src/glyph_encoder.sv
      - src/status_appender.sv
      - src/board_display_top.sv
  - target: test
    files:
      - verification/tb_board_display.sv
